// ==== mgmt_pkg.sv ====
// Fixed 64-bit bus only; opcodes outside the defined set are treated as unknown and flushed
package mgmt_pkg;

  // --------------------------------------------------
  // Packet word layouts
  // --------------------------------------------------

  // Chassis header with flags and seq_num carried through untouched
  typedef struct packed {
    logic [7:0]  flags;
    logic [2:0]  pkt_type;
    logic [4:0]  num_mdata;
    logic [15:0] seq_num;
    logic [15:0] length;
    logic [15:0] dst_epid;
  } chdr_hdr_t;

  // Management header, first word after the chassis header
  typedef struct packed {
    logic [15:0] protover;
    logic [2:0]  chdr_w;
    logic [18:0] rsvd;
    logic [9:0]  num_hops;
    logic [15:0] src_epid;
  } mgmt_hdr_t;

  // One operation word
  // Config ops put addr in payload[15:0] and data in payload[47:16]
  typedef struct packed {
    logic [47:0] payload;
    logic [7:0]  ops_pending;
    logic [7:0]  op_code;
  } mgmt_op_t;

  // Response entry, later expanded to an op word with ops_pending filled in
  typedef struct packed {
    logic [47:0] payload;
    logic [7:0]  op_code;
  } mgmt_resp_t;

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------
  localparam logic [7:0] OP_NOP         = 8'd0;
  localparam logic [7:0] OP_ADVERTISE   = 8'd1;
  localparam logic [7:0] OP_SEL_DEST    = 8'd2;
  localparam logic [7:0] OP_RETURN      = 8'd3;
  localparam logic [7:0] OP_INFO_REQ    = 8'd4;
  localparam logic [7:0] OP_INFO_RESP   = 8'd5;
  localparam logic [7:0] OP_CFG_WR_REQ  = 8'd6;
  localparam logic [7:0] OP_CFG_RD_REQ  = 8'd7;
  localparam logic [7:0] OP_CFG_RD_RESP = 8'd8;

  // Routing mode carried on tid
  localparam logic [1:0] ROUTE_EPID   = 2'd0;
  localparam logic [1:0] ROUTE_TDEST  = 2'd1;
  localparam logic [1:0] ROUTE_RETURN = 2'd2;

  localparam logic [2:0]  PKT_TYPE_MGMT  = 3'd0;
  localparam logic [2:0]  CHDR_W_CODE_64 = 3'd0;
  localparam logic [15:0] WORD_BYTES     = 16'd8;

  // Packet FSM states, shared by all three stages
  typedef enum logic [3:0] {
    IN_CHDR_HDR,
    IN_MGMT_HDR,
    OP_EXEC,
    OP_WAIT,
    OP_DONE,
    OUT_CHDR_HDR,
    OUT_MGMT_HDR,
    PASS_PAYLOAD,
    MOD_LAST_HOP,
    POP_RESP,
    APPEND_RESP,
    DROP
  } pkt_state_t;

  // --------------------------------------------------
  // Port bundles
  // --------------------------------------------------
  typedef struct packed {
    logic [63:0] data;
    logic        last;
  } chdr_in_t;

  typedef struct packed {
    logic [63:0] data;
    logic [1:0]  tid;
    logic [9:0]  tdest;
    logic        last;
  } chdr_out_t;

  typedef struct packed {
    logic        wr;
    logic        rd;
    logic [15:0] addr;
    logic [31:0] data;
  } ctrl_req_t;

  typedef struct packed {
    logic        stb;
    logic [15:0] dst_epid;
    logic [15:0] src_epid;
  } adv_t;

endpackage

// ==== mgmt_flop.sv ====
// Single-entry slice; payload is not reset, so o_data is only meaningful while o_valid is high
module mgmt_flop #(
  parameter type T = logic [63:0]
) (
  input  logic clk,
  input  logic rst,
  input  T     i_data,
  input  logic i_valid,
  output logic o_ready,
  output T     o_data,
  output logic o_valid,
  input  logic i_ready
);

  // Take a word when empty or when the held word leaves this cycle
  assign o_ready = !o_valid || i_ready;

  // Valid bit
  always_ff @(posedge clk) begin
    if (rst) begin
      o_valid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (o_ready && i_valid) begin
      o_data <= i_data;
    end
  end

endmodule

// ==== mgmt_resp_fifo.sv ====
// Depth is 2**RESP_DEPTH_LOG2; pushes into a full FIFO are lost and o_count wraps at 256 entries
module mgmt_resp_fifo #(
  parameter int RESP_DEPTH_LOG2 = 5
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 i_clear,
  input  logic                 i_push,
  input  mgmt_pkg::mgmt_resp_t i_resp,
  input  logic                 i_pop,
  output mgmt_pkg::mgmt_resp_t o_resp,
  output logic                 o_avail,
  output logic [7:0]           o_count
);
  import mgmt_pkg::*;

  localparam int DEPTH = 1 << RESP_DEPTH_LOG2;

  mgmt_resp_t                 mem [DEPTH];
  logic [RESP_DEPTH_LOG2-1:0] wr_ptr;
  logic [RESP_DEPTH_LOG2-1:0] rd_ptr;
  logic [RESP_DEPTH_LOG2:0]   count;
  logic                       push_ok;
  logic                       pop_ok;

  assign push_ok = i_push && (count != DEPTH[RESP_DEPTH_LOG2:0]);
  assign pop_ok  = i_pop && o_avail;
  assign o_avail = (count != '0);
  assign o_count = 8'(count);
  assign o_resp  = mem[rd_ptr];

  // Pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk) begin
    if (rst || i_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push_ok && !pop_ok) begin
        count <= count + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= i_resp;
    end
  end

endmodule

// ==== mgmt_hop_parser.sv ====
// Management packets only; metadata or a foreign pkt_type sends the packet to DROP
module mgmt_hop_parser (
  input  logic                 clk,
  input  logic                 rst,
  input  mgmt_pkg::chdr_in_t   i_in,
  input  logic                 i_in_valid,
  output logic                 o_in_ready,
  input  logic                 i_out_ready,
  input  logic                 i_op_complete,
  input  logic                 i_op_abort,
  input  logic                 i_resp_avail,
  output mgmt_pkg::pkt_state_t o_state,
  output mgmt_pkg::chdr_hdr_t  o_chdr_hdr,
  output mgmt_pkg::mgmt_hdr_t  o_mgmt_hdr,
  output logic [15:0]          o_stripped_len,
  output logic [9:0]           o_hops_left
);
  import mgmt_pkg::*;

  pkt_state_t state;
  chdr_hdr_t  in_chdr;
  mgmt_hdr_t  in_mgmt;
  mgmt_op_t   in_op;
  logic       in_xfer;
  logic       hop_end;
  logic [9:0] hops_dec;

  // Views of the current input word
  assign in_chdr  = i_in.data;
  assign in_mgmt  = i_in.data;
  assign in_op    = i_in.data;
  assign in_xfer  = i_in_valid && o_in_ready;
  assign hop_end  = (in_op.ops_pending == 8'd0);
  assign hops_dec = o_hops_left - 10'd1;
  assign o_state  = state;

  // --------------------------------------------------
  // Packet FSM
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IN_CHDR_HDR;
    end else begin
      case (state)
        IN_CHDR_HDR: begin
          if (in_xfer) begin
            if (i_in.last) begin
              state <= IN_CHDR_HDR;
            end else if (in_chdr.pkt_type != PKT_TYPE_MGMT || in_chdr.num_mdata != 5'd0) begin
              state <= DROP;
            end else begin
              state <= IN_MGMT_HDR;
            end
          end
        end
        IN_MGMT_HDR: begin
          if (in_xfer) begin
            state <= i_in.last ? IN_CHDR_HDR : OP_EXEC;
          end
        end
        // Op word is held here until the execute stage decides
        OP_EXEC: begin
          if (i_op_abort) begin
            state <= DROP;
          end else if (i_op_complete) begin
            state <= OP_DONE;
          end else if (i_in_valid) begin
            state <= OP_WAIT;
          end
        end
        OP_WAIT: begin
          if (i_op_complete) begin
            state <= OP_DONE;
          end
        end
        // Consume the op word, then next op or start the output
        OP_DONE: begin
          if (in_xfer) begin
            if (i_in.last) begin
              state <= IN_CHDR_HDR;
            end else begin
              state <= hop_end ? OUT_CHDR_HDR : OP_EXEC;
            end
          end
        end
        OUT_CHDR_HDR: begin
          if (i_out_ready) begin
            state <= OUT_MGMT_HDR;
          end
        end
        OUT_MGMT_HDR: begin
          if (i_out_ready) begin
            state <= (i_resp_avail && o_hops_left == 10'd1) ? MOD_LAST_HOP : PASS_PAYLOAD;
          end
        end
        // One hop left once the current hop ends means the next one is last
        PASS_PAYLOAD: begin
          if (in_xfer) begin
            if (i_in.last) begin
              state <= IN_CHDR_HDR;
            end else if (hop_end && i_resp_avail && hops_dec == 10'd1) begin
              state <= MOD_LAST_HOP;
            end
          end
        end
        MOD_LAST_HOP: begin
          if (in_xfer && hop_end) begin
            if (i_resp_avail) begin
              state <= POP_RESP;
            end else begin
              state <= i_in.last ? IN_CHDR_HDR : DROP;
            end
          end
        end
        POP_RESP: begin
          if (i_resp_avail) begin
            state <= APPEND_RESP;
          end
        end
        APPEND_RESP: begin
          if (i_out_ready) begin
            state <= i_resp_avail ? POP_RESP : IN_CHDR_HDR;
          end
        end
        DROP: begin
          if (in_xfer && i_in.last) begin
            state <= IN_CHDR_HDR;
          end
        end
        default: begin
          state <= IN_CHDR_HDR;
        end
      endcase
    end
  end

  // Cached headers, stripped length and hop count
  always_ff @(posedge clk) begin
    if (state == IN_CHDR_HDR && in_xfer) begin
      o_chdr_hdr     <= in_chdr;
      o_stripped_len <= in_chdr.length;
    end
    if (state == IN_MGMT_HDR && in_xfer) begin
      o_mgmt_hdr  <= in_mgmt;
      o_hops_left <= in_mgmt.num_hops;
    end
    // Each first-hop op word is removed from the packet
    if (state == OP_DONE && in_xfer && !i_in.last) begin
      o_stripped_len <= o_stripped_len - WORD_BYTES;
      if (hop_end) begin
        o_hops_left <= hops_dec;
      end
    end
    if (state == PASS_PAYLOAD && in_xfer && !i_in.last && hop_end) begin
      o_hops_left <= hops_dec;
    end
  end

  // Input ready per state
  always_comb begin
    case (state)
      IN_CHDR_HDR, IN_MGMT_HDR, OP_DONE, DROP: o_in_ready = 1'b1;
      PASS_PAYLOAD, MOD_LAST_HOP:              o_in_ready = i_out_ready;
      default:                                 o_in_ready = 1'b0;
    endcase
  end

endmodule

// ==== mgmt_op_exec.sv ====
// First-hop ops only; a control-port request blocks the packet until its ack, with no timeout
module mgmt_op_exec (
  input  logic                 clk,
  input  logic                 rst,
  input  mgmt_pkg::pkt_state_t i_state,
  input  mgmt_pkg::chdr_in_t   i_in,
  input  logic                 i_in_valid,
  input  mgmt_pkg::chdr_hdr_t  i_chdr_hdr,
  input  mgmt_pkg::mgmt_hdr_t  i_mgmt_hdr,
  input  logic [47:0]          i_node_info,
  output mgmt_pkg::ctrl_req_t  o_ctrl,
  input  logic                 i_ctrl_ack,
  input  logic [31:0]          i_ctrl_resp_data,
  output mgmt_pkg::adv_t       o_adv,
  output logic                 o_op_complete,
  output logic                 o_op_abort,
  output logic [1:0]           o_tid,
  output logic [9:0]           o_tdest,
  output logic                 o_resp_push,
  output mgmt_pkg::mgmt_resp_t o_resp
);
  import mgmt_pkg::*;

  mgmt_op_t    op;
  logic        single_op;
  logic        cfg_op;
  logic        exec_go;
  logic        in_wait;
  logic        in_done;
  logic        req_wr;
  logic        req_rd;
  logic [15:0] req_addr;
  logic [31:0] req_data;

  assign op      = i_in.data;
  assign exec_go = i_in_valid && (i_state == OP_EXEC);
  assign in_wait = i_in_valid && (i_state == OP_WAIT);
  assign in_done = i_in_valid && (i_state == OP_DONE);

  // Opcode classes, response opcodes count as no-ops
  always_comb begin
    single_op = 1'b0;
    cfg_op    = 1'b0;
    case (op.op_code)
      OP_NOP, OP_ADVERTISE, OP_SEL_DEST, OP_RETURN,
      OP_INFO_REQ, OP_INFO_RESP, OP_CFG_RD_RESP: single_op = 1'b1;
      OP_CFG_WR_REQ, OP_CFG_RD_REQ:              cfg_op = 1'b1;
      default:                                   single_op = 1'b0;
    endcase
  end

  assign o_op_complete = (exec_go && single_op) || (in_wait && i_ctrl_ack);
  assign o_op_abort    = exec_go && !single_op && !cfg_op;

  // --------------------------------------------------
  // Control port and route
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      req_wr  <= 1'b0;
      req_rd  <= 1'b0;
      o_tid   <= ROUTE_EPID;
      o_tdest <= 10'd0;
    end else begin
      // Pulses for one cycle since OP_EXEC moves on to OP_WAIT
      req_wr <= exec_go && (op.op_code == OP_CFG_WR_REQ);
      req_rd <= exec_go && (op.op_code == OP_CFG_RD_REQ);
      // Every op resets the route unless it picks one
      if (exec_go) begin
        o_tid   <= ROUTE_EPID;
        o_tdest <= 10'd0;
        if (op.op_code == OP_SEL_DEST) begin
          o_tid   <= ROUTE_TDEST;
          o_tdest <= op.payload[9:0];
        end else if (op.op_code == OP_RETURN) begin
          o_tid <= ROUTE_RETURN;
        end
      end
    end
  end

  // Address and data, also reused for the read response
  always_ff @(posedge clk) begin
    if (exec_go) begin
      req_addr <= op.payload[15:0];
      req_data <= op.payload[47:16];
    end
  end

  assign o_ctrl = '{wr: req_wr, rd: req_rd, addr: req_addr, data: req_data};

  // Advertisement with the endpoint IDs of the cached headers
  assign o_adv.stb      = in_done && (op.op_code == OP_ADVERTISE);
  assign o_adv.dst_epid = i_chdr_hdr.dst_epid;
  assign o_adv.src_epid = i_mgmt_hdr.src_epid;

  // Responses in issue order
  assign o_resp_push = (in_wait && i_ctrl_ack && op.op_code == OP_CFG_RD_REQ) ||
                       (in_done && op.op_code == OP_INFO_REQ);
  assign o_resp = (op.op_code == OP_CFG_RD_REQ) ?
                  '{payload: {i_ctrl_resp_data, req_addr}, op_code: OP_CFG_RD_RESP} :
                  '{payload: i_node_info, op_code: OP_INFO_RESP};

endmodule

// ==== mgmt_pkt_builder.sv ====
// Responses go on the last hop only; reserved mgmt header bits are written as zero
module mgmt_pkt_builder #(
  parameter logic [15:0] PROTOVER        = 16'h0100,
  parameter int          RESP_DEPTH_LOG2 = 5
) (
  input  logic                 clk,
  input  logic                 rst,
  input  mgmt_pkg::pkt_state_t i_state,
  input  mgmt_pkg::chdr_in_t   i_in,
  input  logic                 i_in_valid,
  input  mgmt_pkg::chdr_hdr_t  i_chdr_hdr,
  input  mgmt_pkg::mgmt_hdr_t  i_mgmt_hdr,
  input  logic [15:0]          i_stripped_len,
  input  logic [1:0]           i_tid,
  input  logic [9:0]           i_tdest,
  input  logic                 i_resp_push,
  input  mgmt_pkg::mgmt_resp_t i_resp,
  output logic                 o_resp_avail,
  output logic [7:0]           o_resp_count,
  output mgmt_pkg::chdr_out_t  o_out,
  output logic                 o_out_valid
);
  import mgmt_pkg::*;

  mgmt_resp_t fifo_resp;
  mgmt_resp_t held_resp;
  logic       resp_pop;
  logic       is_return;
  chdr_hdr_t  out_chdr;
  mgmt_hdr_t  out_mgmt;
  mgmt_op_t   in_op;
  mgmt_op_t   mod_op;
  mgmt_op_t   app_op;

  assign resp_pop  = (i_state == POP_RESP) && o_resp_avail;
  assign is_return = (i_tid == ROUTE_RETURN);
  assign in_op     = i_in.data;

  // Emptied at the start of every packet
  mgmt_resp_fifo #(
    .RESP_DEPTH_LOG2(RESP_DEPTH_LOG2)
  ) resp_fifo_inst (
    .clk     (clk),
    .rst     (rst),
    .i_clear (i_state == IN_CHDR_HDR),
    .i_push  (i_resp_push),
    .i_resp  (i_resp),
    .i_pop   (resp_pop),
    .o_resp  (fifo_resp),
    .o_avail (o_resp_avail),
    .o_count (o_resp_count)
  );

  // Popped response waits here for its output slot
  always_ff @(posedge clk) begin
    if (resp_pop) begin
      held_resp <= fifo_resp;
    end
  end

  // --------------------------------------------------
  // Rewritten words
  // --------------------------------------------------
  always_comb begin
    out_chdr          = i_chdr_hdr;
    out_chdr.dst_epid = is_return ? i_mgmt_hdr.src_epid : i_chdr_hdr.dst_epid;
    out_chdr.length   = i_stripped_len + 16'(o_resp_count) * WORD_BYTES;
    out_mgmt          = '0;
    out_mgmt.protover = PROTOVER;
    out_mgmt.chdr_w   = CHDR_W_CODE_64;
    out_mgmt.num_hops = i_mgmt_hdr.num_hops - 10'd1;
    out_mgmt.src_epid = is_return ? i_chdr_hdr.dst_epid : i_mgmt_hdr.src_epid;
    // Last hop announces the responses that follow it
    mod_op             = in_op;
    mod_op.ops_pending = in_op.ops_pending + o_resp_count;
    app_op.payload     = held_resp.payload;
    app_op.ops_pending = o_resp_count;
    app_op.op_code     = held_resp.op_code;
  end

  // Output mux; tid and tdest hold for the whole packet
  always_comb begin
    o_out.tid   = i_tid;
    o_out.tdest = i_tdest;
    o_out.data  = '0;
    o_out.last  = 1'b0;
    o_out_valid = 1'b0;
    case (i_state)
      OUT_CHDR_HDR: begin
        o_out.data  = out_chdr;
        o_out_valid = 1'b1;
      end
      OUT_MGMT_HDR: begin
        o_out.data  = out_mgmt;
        o_out_valid = 1'b1;
      end
      PASS_PAYLOAD: begin
        o_out.data  = i_in.data;
        o_out.last  = i_in.last;
        o_out_valid = i_in_valid;
      end
      MOD_LAST_HOP: begin
        o_out.data  = mod_op;
        o_out.last  = i_in.last && !o_resp_avail;
        o_out_valid = i_in_valid;
      end
      APPEND_RESP: begin
        o_out.data  = app_op;
        o_out.last  = !o_resp_avail;
        o_out_valid = 1'b1;
      end
      default: begin
        o_out_valid = 1'b0;
      end
    endcase
  end

endmodule

// ==== mgmt_node.sv ====
// Management-only 64-bit node; other packet types and packets with metadata are flushed
module mgmt_node #(
  parameter logic [15:0] PROTOVER        = 16'h0100,
  parameter int          RESP_DEPTH_LOG2 = 5
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [47:0]         i_node_info,
  input  mgmt_pkg::chdr_in_t  i_chdr,
  input  logic                i_chdr_valid,
  output logic                o_chdr_ready,
  output mgmt_pkg::chdr_out_t o_chdr,
  output logic                o_chdr_valid,
  input  logic                i_chdr_ready,
  output mgmt_pkg::ctrl_req_t o_ctrl,
  input  logic                i_ctrl_ack,
  input  logic [31:0]         i_ctrl_resp_data,
  output mgmt_pkg::adv_t      o_adv
);
  import mgmt_pkg::*;

  chdr_in_t   in_word;
  logic       in_valid;
  logic       in_ready;
  chdr_out_t  out_word;
  logic       out_valid;
  logic       out_ready;
  pkt_state_t state;
  chdr_hdr_t  chdr_hdr;
  mgmt_hdr_t  mgmt_hdr;
  logic [15:0] stripped_len;
  logic       op_complete;
  logic       op_abort;
  logic [1:0] tid;
  logic [9:0] tdest;
  logic       resp_push;
  mgmt_resp_t resp;
  logic       resp_avail;

  // --------------------------------------------------
  // Stream register slices
  // --------------------------------------------------
  mgmt_flop #(.T(chdr_in_t)) in_flop_inst (
    .clk(clk), .rst(rst),
    .i_data(i_chdr), .i_valid(i_chdr_valid), .o_ready(o_chdr_ready),
    .o_data(in_word), .o_valid(in_valid), .i_ready(in_ready)
  );

  mgmt_flop #(.T(chdr_out_t)) out_flop_inst (
    .clk(clk), .rst(rst),
    .i_data(out_word), .i_valid(out_valid), .o_ready(out_ready),
    .o_data(o_chdr), .o_valid(o_chdr_valid), .i_ready(i_chdr_ready)
  );

  // --------------------------------------------------
  // Decode, execute and result stages
  // --------------------------------------------------
  mgmt_hop_parser parser_inst (
    .clk(clk), .rst(rst),
    .i_in(in_word), .i_in_valid(in_valid), .o_in_ready(in_ready),
    .i_out_ready(out_ready), .i_op_complete(op_complete), .i_op_abort(op_abort),
    .i_resp_avail(resp_avail), .o_state(state), .o_chdr_hdr(chdr_hdr),
    .o_mgmt_hdr(mgmt_hdr), .o_stripped_len(stripped_len), .o_hops_left()
  );

  mgmt_op_exec exec_inst (
    .clk(clk), .rst(rst),
    .i_state(state), .i_in(in_word), .i_in_valid(in_valid),
    .i_chdr_hdr(chdr_hdr), .i_mgmt_hdr(mgmt_hdr), .i_node_info(i_node_info),
    .o_ctrl(o_ctrl), .i_ctrl_ack(i_ctrl_ack), .i_ctrl_resp_data(i_ctrl_resp_data),
    .o_adv(o_adv), .o_op_complete(op_complete), .o_op_abort(op_abort),
    .o_tid(tid), .o_tdest(tdest), .o_resp_push(resp_push), .o_resp(resp)
  );

  mgmt_pkt_builder #(
    .PROTOVER(PROTOVER), .RESP_DEPTH_LOG2(RESP_DEPTH_LOG2)
  ) builder_inst (
    .clk(clk), .rst(rst),
    .i_state(state), .i_in(in_word), .i_in_valid(in_valid),
    .i_chdr_hdr(chdr_hdr), .i_mgmt_hdr(mgmt_hdr), .i_stripped_len(stripped_len),
    .i_tid(tid), .i_tdest(tdest), .i_resp_push(resp_push), .i_resp(resp),
    .o_resp_avail(resp_avail), .o_resp_count(),
    .o_out(out_word), .o_out_valid(out_valid)
  );

endmodule

// ==== mgmt_node_checker.sv ====
// Protocol properties on the output stream and control port, idle during reset
module mgmt_node_checker (
  input logic                clk,
  input logic                rst,
  input mgmt_pkg::chdr_out_t i_chdr_out,
  input logic                i_chdr_out_valid,
  input logic                i_chdr_out_ready,
  input mgmt_pkg::ctrl_req_t i_ctrl
);
  import mgmt_pkg::*;

  // Stalled output word must hold
  assert property (@(posedge clk) disable iff (rst)
    i_chdr_out_valid && !i_chdr_out_ready |=> i_chdr_out_valid && $stable(i_chdr_out))
    else $error("output word changed while stalled");

  // Write and read are exclusive
  assert property (@(posedge clk) disable iff (rst) !(i_ctrl.wr && i_ctrl.rd))
    else $error("control write and read together");

  // Request pulses last one cycle
  assert property (@(posedge clk) disable iff (rst) i_ctrl.wr |=> !i_ctrl.wr)
    else $error("control write longer than one cycle");
  assert property (@(posedge clk) disable iff (rst) i_ctrl.rd |=> !i_ctrl.rd)
    else $error("control read longer than one cycle");

endmodule

bind mgmt_node mgmt_node_checker mgmt_node_checker_inst (
  .clk(clk), .rst(rst), .i_chdr_out(o_chdr), .i_chdr_out_valid(o_chdr_valid),
  .i_chdr_out_ready(i_chdr_ready), .i_ctrl(o_ctrl)
);

// ==== tb_mgmt_node.sv ====
// Random management traffic with a reference model; one-hop packets are consumed with no output
module tb_mgmt_node;
  import mgmt_pkg::*;

  localparam logic [15:0] PROTOVER        = 16'h0200;
  localparam int          RESP_DEPTH_LOG2 = 4;
  localparam int          NUM_PKTS        = 40;
  localparam int          MAX_CYCLES      = 20000;

  logic        clk;
  logic        rst;
  logic [47:0] i_node_info;
  chdr_in_t    i_chdr;
  logic        i_chdr_valid;
  logic        o_chdr_ready;
  chdr_out_t   o_chdr;
  logic        o_chdr_valid;
  logic        i_chdr_ready;
  ctrl_req_t   o_ctrl;
  logic        i_ctrl_ack;
  logic [31:0] i_ctrl_resp_data;
  adv_t        o_adv;

  integer      seed;
  int          errors;
  int          checks;
  chdr_in_t    in_q[$];
  chdr_out_t   exp_out_q[$];
  ctrl_req_t   exp_ctrl_q[$];
  adv_t        exp_adv_q[$];
  logic [31:0] rd_data_q[$];

  mgmt_node #(
    .PROTOVER(PROTOVER), .RESP_DEPTH_LOG2(RESP_DEPTH_LOG2)
  ) mgmt_node_inst (
    .clk(clk), .rst(rst), .i_node_info(i_node_info),
    .i_chdr(i_chdr), .i_chdr_valid(i_chdr_valid), .o_chdr_ready(o_chdr_ready),
    .o_chdr(o_chdr), .o_chdr_valid(o_chdr_valid), .i_chdr_ready(i_chdr_ready),
    .o_ctrl(o_ctrl), .i_ctrl_ack(i_ctrl_ack), .i_ctrl_resp_data(i_ctrl_resp_data),
    .o_adv(o_adv)
  );

  always #20 clk = ~clk;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic int rand_below(int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] a;
    logic [31:0] b;
    a = $random(seed);
    b = $random(seed);
    return {a, b};
  endfunction

  task automatic check_value(input logic [127:0] got, input logic [127:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s: got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Packet with a foreign type or metadata that is flushed without output
  task automatic gen_drop_packet();
    chdr_hdr_t ch;
    chdr_in_t  w;
    int        n;
    ch = rand64();
    if (rand_below(2) == 0) begin
      ch.pkt_type = 3'(1 + rand_below(7));
    end else begin
      ch.pkt_type  = PKT_TYPE_MGMT;
      ch.num_mdata = 5'(1 + rand_below(31));
    end
    n = 2 + rand_below(4);
    in_q.push_back('{data: ch, last: 1'b0});
    for (int i = 1; i < n; i++) begin
      w.data = rand64();
      w.last = (i == n - 1);
      in_q.push_back(w);
    end
  endtask

  // Builds one packet and the words, requests and strobes it must produce
  task automatic gen_mgmt_packet();
    chdr_hdr_t  ch;
    mgmt_hdr_t  mh;
    mgmt_op_t   op;
    chdr_hdr_t  och;
    mgmt_hdr_t  omh;
    chdr_in_t   ops_in[$];
    mgmt_op_t   later_ops[$];
    logic       later_mod[$];
    logic       later_last[$];
    mgmt_resp_t resps[$];
    logic [1:0] route;
    logic [9:0] tdest;
    logic [31:0] rdat;
    int         hops;
    int         nops;
    int         n0;
    hops  = 1 + rand_below(3);
    route = ROUTE_EPID;
    tdest = 10'd0;
    n0    = 0;
    ch    = rand64();
    mh    = rand64();
    for (int h = 0; h < hops; h++) begin
      nops = 1 + rand_below(4);
      for (int i = 0; i < nops; i++) begin
        op.op_code     = 8'(rand_below(9));
        op.ops_pending = 8'(nops - 1 - i);
        op.payload     = 48'(rand64());
        ops_in.push_back('{data: op, last: (h == hops - 1) && (i == nops - 1)});
        if (h == 0) begin
          // Only the first hop runs here and the route follows its last op
          n0++;
          route = ROUTE_EPID;
          tdest = 10'd0;
          case (op.op_code)
            OP_SEL_DEST: begin
              route = ROUTE_TDEST;
              tdest = op.payload[9:0];
            end
            OP_RETURN:    route = ROUTE_RETURN;
            OP_ADVERTISE: exp_adv_q.push_back('{1'b1, ch.dst_epid, mh.src_epid});
            OP_INFO_REQ:  resps.push_back('{i_node_info, OP_INFO_RESP});
            OP_CFG_WR_REQ: begin
              exp_ctrl_q.push_back('{1'b1, 1'b0, op.payload[15:0], op.payload[47:16]});
            end
            OP_CFG_RD_REQ: begin
              rdat = 32'(rand64());
              rd_data_q.push_back(rdat);
              exp_ctrl_q.push_back('{1'b0, 1'b1, op.payload[15:0], op.payload[47:16]});
              resps.push_back('{{rdat, op.payload[15:0]}, OP_CFG_RD_RESP});
            end
            default: ;
          endcase
        end else begin
          later_ops.push_back(op);
          later_mod.push_back(h == hops - 1);
          later_last.push_back((h == hops - 1) && (i == nops - 1));
        end
      end
    end
    ch.pkt_type  = PKT_TYPE_MGMT;
    ch.num_mdata = 5'd0;
    ch.length    = 16'(8 * (2 + ops_in.size()));
    mh.num_hops  = 10'(hops);
    in_q.push_back('{data: ch, last: 1'b0});
    in_q.push_back('{data: mh, last: 1'b0});
    foreach (ops_in[i]) in_q.push_back(ops_in[i]);
    if (hops == 1) return;
    och          = ch;
    och.dst_epid = (route == ROUTE_RETURN) ? mh.src_epid : ch.dst_epid;
    och.length   = ch.length - 16'(8 * n0) + 16'(8 * resps.size());
    omh          = '0;
    omh.protover = PROTOVER;
    omh.chdr_w   = CHDR_W_CODE_64;
    omh.num_hops = 10'(hops - 1);
    omh.src_epid = (route == ROUTE_RETURN) ? ch.dst_epid : mh.src_epid;
    exp_out_q.push_back('{och, route, tdest, 1'b0});
    exp_out_q.push_back('{omh, route, tdest, 1'b0});
    foreach (later_ops[i]) begin
      op = later_ops[i];
      if (later_mod[i]) op.ops_pending = op.ops_pending + 8'(resps.size());
      exp_out_q.push_back('{op, route, tdest, later_last[i] && (resps.size() == 0)});
    end
    // Appended responses count down to zero
    foreach (resps[k]) begin
      op = '{resps[k].payload, 8'(resps.size() - 1 - k), resps[k].op_code};
      exp_out_q.push_back('{op, route, tdest, k == resps.size() - 1});
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    int          cycles;
    int          quiet;
    int          ack_wait;
    logic        ack_pending;
    logic [31:0] ack_data;
    seed = 70;
    errors = 0;
    checks = 0;
    clk = 1'b0;
    rst = 1'b1;
    i_chdr = '0;
    i_chdr_valid = 1'b0;
    i_chdr_ready = 1'b0;
    i_ctrl_ack = 1'b0;
    i_ctrl_resp_data = '0;
    i_node_info = 48'(rand64());
    ack_pending = 1'b0;
    ack_wait = 0;
    ack_data = '0;
    for (int p = 0; p < NUM_PKTS; p++) begin
      if (rand_below(5) == 0) gen_drop_packet();
      else gen_mgmt_packet();
    end
    for (int i = 0; i < 3; i++) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    cycles = 0;
    quiet = 0;
    while (cycles < MAX_CYCLES && quiet < 20) begin
      @(negedge clk);
      i_chdr_valid = (in_q.size() > 0);
      i_chdr = (in_q.size() > 0) ? in_q[0] : '0;
      i_chdr_ready = (rand_below(4) != 0);
      i_ctrl_ack = 1'b0;
      if (ack_pending) begin
        if (ack_wait == 0) begin
          i_ctrl_ack = 1'b1;
          i_ctrl_resp_data = ack_data;
          ack_pending = 1'b0;
        end else begin
          ack_wait--;
        end
      end
      // Everything is settled until the next rising edge
      #10;
      if (i_chdr_valid && o_chdr_ready) void'(in_q.pop_front());
      if (o_chdr_valid && i_chdr_ready) begin
        if (exp_out_q.size() == 0) begin
          errors++;
          $display("Unexpected output word %h at time %0t", o_chdr, $time);
        end else begin
          check_value(128'(o_chdr), 128'(exp_out_q.pop_front()), "output word");
        end
      end
      if (o_ctrl.wr || o_ctrl.rd) begin
        if (exp_ctrl_q.size() == 0) begin
          errors++;
          $display("Unexpected control request at time %0t", $time);
        end else begin
          check_value(128'(o_ctrl), 128'(exp_ctrl_q.pop_front()), "control request");
        end
        ack_data = (o_ctrl.rd && rd_data_q.size() > 0) ? rd_data_q.pop_front() :
                   32'(rand64());
        ack_pending = 1'b1;
        ack_wait = rand_below(6);
      end
      if (o_adv.stb) begin
        if (exp_adv_q.size() == 0) begin
          errors++;
          $display("Unexpected advertisement strobe at time %0t", $time);
        end else begin
          check_value(128'(o_adv), 128'(exp_adv_q.pop_front()), "advertisement");
        end
      end
      if (in_q.size() == 0 && exp_out_q.size() == 0 && exp_ctrl_q.size() == 0 &&
          exp_adv_q.size() == 0 && !ack_pending) begin
        quiet++;
      end else begin
        quiet = 0;
      end
      cycles++;
    end
    if (cycles >= MAX_CYCLES) begin
      errors++;
      $display("Timeout: %0d output words still expected", exp_out_q.size());
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
mgmt_pkg.sv
mgmt_flop.sv
mgmt_resp_fifo.sv
mgmt_hop_parser.sv
mgmt_op_exec.sv
mgmt_pkt_builder.sv
mgmt_node.sv
mgmt_node_checker.sv
tb_mgmt_node.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_mgmt_node
RTL_TOP    := mgmt_node
FILELIST   := tb.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
SIM_BIN    := sim_$(TOP)
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(SIM_BIN)
	./$(OBJ_DIR)/$(SIM_BIN) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
